// File: logic/stripe_pkg.sv
// stripe_pkg holds the sizes and word types shared by the striped word buffer

package stripe_pkg;

  // ----------------------------------------
  // base sizes
  // ----------------------------------------

  // number of lane fifos the stream is spread over
  localparam int lane_count = 4;
  // words per lane, must be a power of two
  localparam int lane_depth = 4;
  // payload width
  localparam int data_w = 32;

  // ----------------------------------------
  // derived widths
  // ----------------------------------------

  // lane index
  localparam int lane_w = $clog2(lane_count);
  // pointer into one lane
  localparam int ptr_w = $clog2(lane_depth);
  // occupancy and credit, one extra bit to hold the full value
  localparam int cnt_w = ptr_w + 1;

  // word on every data port
  typedef logic [data_w-1:0] word_t;
  // round-robin lane pointer
  typedef logic [lane_w-1:0] lane_sel_t;

endpackage

// File: logic/lane_fifo.sv
// lane_fifo is a first-word-fall-through register queue for one stripe lane

`timescale 1ns/1ns

module lane_fifo (
  input  logic                clk,
  input  logic                nrst,

  // write side, from the dispatcher
  input  logic                push,
  input  stripe_pkg::word_t   push_data,

  // read side, to the collector
  input  logic                pop,
  output stripe_pkg::word_t   head_data,
  output logic                empty
);

  // ----------------------------------------
  // storage and pointers
  // ----------------------------------------

  // circular word array, no reset on payload
  stripe_pkg::word_t mem [stripe_pkg::lane_depth];

  // write and read positions
  logic [stripe_pkg::ptr_w-1:0] wr_ptr;
  logic [stripe_pkg::ptr_w-1:0] rd_ptr;

  // words currently held, 0 up to lane_depth
  logic [stripe_pkg::cnt_w-1:0] count;

  // ----------------------------------------
  // write port
  // ----------------------------------------

  // push always lands at wr_ptr
  // credits upstream keep it from hitting a full lane
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ----------------------------------------
  // pointer and occupancy update
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!nrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // lane_depth is a power of two, so pointers wrap on their own
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      // push and pop together leave the count alone
      unique case ({push, pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  // ----------------------------------------
  // head of queue
  // ----------------------------------------

  // empty straight from the counter
  assign empty = (count == '0);

  // fall-through head, the word at rd_ptr with no read request
  // forced to zero when nothing is held
  always_comb begin
    if (empty) begin
      head_data = '0;
    end else begin
      head_data = mem[rd_ptr];
    end
  end

endmodule

// File: logic/stripe_dispatch.sv
// stripe_dispatch spreads input words round-robin over the lanes under credit control

`timescale 1ns/1ns

module stripe_dispatch (
  input  logic                                clk,
  input  logic                                nrst,

  // source handshake
  input  logic                                in_valid,
  input  stripe_pkg::word_t                   in_data,
  output logic                                in_ready,

  // lane write side
  output logic [stripe_pkg::lane_count-1:0]   push,
  output stripe_pkg::word_t                   push_data,

  // credit return from the collector
  input  logic [stripe_pkg::lane_count-1:0]   pop
);

  // ----------------------------------------
  // state
  // ----------------------------------------

  // free slots per lane, starts at lane_depth
  logic [stripe_pkg::cnt_w-1:0] credit [stripe_pkg::lane_count];

  // lane that takes the next word
  stripe_pkg::lane_sel_t wr_lane;

  // input transfer this cycle
  logic accept;

  // ready only depends on the current lane's credit, never on in_valid
  assign in_ready = (credit[wr_lane] != '0);
  assign accept   = in_valid && in_ready;

  // one data bus shared by every lane
  assign push_data = in_data;

  // one-hot push toward wr_lane
  always_comb begin
    for (int k = 0; k < stripe_pkg::lane_count; k++) begin
      push[k] = accept && (wr_lane == stripe_pkg::lane_w'(k));
    end
  end

  // ----------------------------------------
  // credit counters and write pointer
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!nrst) begin
      wr_lane <= '0;
      for (int k = 0; k < stripe_pkg::lane_count; k++) begin
        credit[k] <= stripe_pkg::cnt_w'(stripe_pkg::lane_depth);
      end
    end else begin
      // step the pointer modulo lane_count
      if (accept) begin
        if (wr_lane == stripe_pkg::lane_w'(stripe_pkg::lane_count - 1)) begin
          wr_lane <= '0;
        end else begin
          wr_lane <= wr_lane + 1'b1;
        end
      end

      // push spends a credit, pop gives one back, both cancel
      for (int k = 0; k < stripe_pkg::lane_count; k++) begin
        if (push[k] && !pop[k]) begin
          credit[k] <= credit[k] - 1'b1;
        end else if (pop[k] && !push[k]) begin
          credit[k] <= credit[k] + 1'b1;
        end
      end
    end
  end

endmodule

// File: logic/stripe_collect.sv
// stripe_collect drains the lanes round-robin and hands credits back to the dispatcher

`timescale 1ns/1ns

module stripe_collect (
  input  logic                                                    clk,
  input  logic                                                    nrst,

  // lane heads and status
  input  stripe_pkg::word_t [stripe_pkg::lane_count-1:0]          lane_data,
  input  logic [stripe_pkg::lane_count-1:0]                       lane_empty,

  // sink handshake
  output logic                                                    out_valid,
  output stripe_pkg::word_t                                       out_data,
  input  logic                                                    out_ready,

  // head removal, doubles as credit return
  output logic [stripe_pkg::lane_count-1:0]                       pop
);

  // ----------------------------------------
  // read pointer
  // ----------------------------------------

  // lane holding the oldest word
  stripe_pkg::lane_sel_t rd_lane;

  // output transfer this cycle
  logic take;

  // ----------------------------------------
  // output selection
  // ----------------------------------------

  // valid follows the selected lane directly
  assign out_valid = !lane_empty[rd_lane];
  // head is zero for an empty lane, harmless as valid is low then
  assign out_data  = lane_data[rd_lane];

  assign take = out_valid && out_ready;

  // one-hot pop for the lane just read
  always_comb begin
    for (int k = 0; k < stripe_pkg::lane_count; k++) begin
      pop[k] = take && (rd_lane == stripe_pkg::lane_w'(k));
    end
  end

  // ----------------------------------------
  // pointer advance
  // ----------------------------------------

  // same lane order as the dispatcher, so words leave in arrival order
  always_ff @(posedge clk) begin
    if (!nrst) begin
      rd_lane <= '0;
    end else if (take) begin
      if (rd_lane == stripe_pkg::lane_w'(stripe_pkg::lane_count - 1)) begin
        rd_lane <= '0;
      end else begin
        rd_lane <= rd_lane + 1'b1;
      end
    end
  end

  // holding out_data under back-pressure needs nothing extra here
  // the selected lane is not popped and pushes land behind its head

endmodule

// File: logic/stripe_buffer.sv
// stripe_buffer is an in-order word buffer striped over four credit-fed lane fifos

`timescale 1ns/1ns

module stripe_buffer (
  input  logic                clk,
  input  logic                nrst,

  // input stream
  input  logic                in_valid,
  input  stripe_pkg::word_t   in_data,
  output logic                in_ready,

  // output stream
  output logic                out_valid,
  output stripe_pkg::word_t   out_data,
  input  logic                out_ready
);

  // ----------------------------------------
  // internal nets
  // ----------------------------------------

  // dispatcher to lanes
  logic [stripe_pkg::lane_count-1:0]                push;
  stripe_pkg::word_t                                push_data;

  // lanes to collector
  stripe_pkg::word_t [stripe_pkg::lane_count-1:0]   lane_data;
  logic [stripe_pkg::lane_count-1:0]                lane_empty;

  // collector to lanes, also the credit return
  logic [stripe_pkg::lane_count-1:0]                pop;

  // input side
  stripe_dispatch i_dispatch (
    .clk       (clk),
    .nrst      (nrst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .push      (push),
    .push_data (push_data),
    .pop       (pop)
  );

  // one fifo per lane
  for (genvar g = 0; g < stripe_pkg::lane_count; g++) begin : g_lane
    lane_fifo i_lane (
      .clk       (clk),
      .nrst      (nrst),
      .push      (push[g]),
      .push_data (push_data),
      .pop       (pop[g]),
      .head_data (lane_data[g]),
      .empty     (lane_empty[g])
    );
  end

  // output side
  stripe_collect i_collect (
    .clk        (clk),
    .nrst       (nrst),
    .lane_data  (lane_data),
    .lane_empty (lane_empty),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready),
    .pop        (pop)
  );

endmodule

// File: dv/stripe_buffer_props.sv
// stripe_buffer_props checks lane occupancy rules inside every lane fifo

`timescale 1ns/1ns

module stripe_buffer_props (
  input logic                          clk,
  input logic                          nrst,
  input logic                          push,
  input logic                          pop,
  input logic                          empty,
  input logic [stripe_pkg::cnt_w-1:0]  count
);

  // failed assertions in this lane, read by the testbench
  int fail_count = 0;

  // ----------------------------------------
  // occupancy rules
  // ----------------------------------------

  // credits upstream must keep a full lane from being written
  push_when_full: assert property (@(posedge clk) disable iff (!nrst)
    !(push && (count == stripe_pkg::cnt_w'(stripe_pkg::lane_depth))))
    else begin
      fail_count++;
      $error("lane written while holding lane_depth words");
    end

  // collector only pops a lane that shows a head word
  pop_when_empty: assert property (@(posedge clk) disable iff (!nrst)
    !(pop && empty))
    else begin
      fail_count++;
      $error("lane popped while empty");
    end

  // counter range
  count_in_range: assert property (@(posedge clk) disable iff (!nrst)
    count <= stripe_pkg::cnt_w'(stripe_pkg::lane_depth))
    else begin
      fail_count++;
      $error("lane occupancy above lane_depth");
    end

endmodule

// attach to each lane instance
bind lane_fifo stripe_buffer_props i_props (
  .clk   (clk),
  .nrst  (nrst),
  .push  (push),
  .pop   (pop),
  .empty (empty),
  .count (count)
);

// File: dv/stripe_buffer_tb.sv
// stripe_buffer_tb runs directed tests on the striped word buffer against a reference queue

`timescale 1ns/1ns

module stripe_buffer_tb;

  // cycles any single wait may take
  localparam int wait_limit = 400;

  logic              clk;
  logic              nrst;
  logic              in_valid;
  stripe_pkg::word_t in_data;
  logic              in_ready;
  logic              out_valid;
  stripe_pkg::word_t out_data;
  logic              out_ready;

  // expected output order
  stripe_pkg::word_t expq [$];
  logic [15:0]       lfsr_state;

  // lanes whose bound checker saw a failed assertion
  wire [stripe_pkg::lane_count-1:0] lane_bad;

  stripe_buffer i_stripe_buffer (
    .clk       (clk),
    .nrst      (nrst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  for (genvar g = 0; g < stripe_pkg::lane_count; g++) begin : g_lane_bad
    assign lane_bad[g] = (i_stripe_buffer.g_lane[g].i_lane.i_props.fail_count != 0);
  end

  // 100 ns period
  always #50 clk = ~clk;

  // ----------------------------------------
  // stimulus source
  // ----------------------------------------

  // 16-bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one step per bit taken
  task automatic take_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic draw_word(output stripe_pkg::word_t w);
    logic b;
    for (int i = 0; i < stripe_pkg::data_w; i++) begin
      take_bit(b);
      w[i] = b;
    end
  endtask

  // ----------------------------------------
  // checking
  // ----------------------------------------

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    stop_run();
  endtask

  task automatic check_word(input string name, input stripe_pkg::word_t got,
                            input stripe_pkg::word_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // ----------------------------------------
  // handshake helpers, entered on a falling edge
  // ----------------------------------------

  // word goes into the queue once the transfer edge is certain
  task automatic send_word(input stripe_pkg::word_t w);
    int n;
    n = 0;
    in_valid = 1'b1;
    in_data  = w;
    while (!in_ready) begin
      @(negedge clk);
      n++;
      if (n > wait_limit) begin
        report_error("in_ready stayed low too long");
      end
    end
    expq.push_back(w);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic recv_word();
    int n;
    n = 0;
    out_ready = 1'b1;
    while (!out_valid) begin
      @(negedge clk);
      n++;
      if (n > wait_limit) begin
        report_error("out_valid stayed low too long");
      end
    end
    if (expq.size() == 0) begin
      report_error("output word with nothing expected");
    end
    check_word("out_data", out_data, expq.pop_front());
    @(negedge clk);
    out_ready = 1'b0;
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------

  task automatic test_reset_state();
    check_flag("in_ready", in_ready, 1'b1);
    check_flag("out_valid", out_valid, 1'b0);
  endtask

  task automatic test_single_word();
    stripe_pkg::word_t w;
    draw_word(w);
    send_word(w);
    // visible one cycle after the accept edge
    check_flag("out_valid", out_valid, 1'b1);
    check_word("out_data", out_data, w);
    recv_word();
    check_flag("out_valid", out_valid, 1'b0);
  endtask

  task automatic test_lane_order();
    stripe_pkg::word_t words [40];
    for (int i = 0; i < 40; i++) begin
      draw_word(words[i]);
    end
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          send_word(words[i]);
        end
      end
      begin
        for (int i = 0; i < 40; i++) begin
          recv_word();
        end
      end
    join
    check_flag("out_valid", out_valid, 1'b0);
  endtask

  task automatic test_capacity();
    stripe_pkg::word_t w;
    out_ready = 1'b0;
    for (int i = 0; i < stripe_pkg::lane_count * stripe_pkg::lane_depth; i++) begin
      check_flag("in_ready", in_ready, 1'b1);
      draw_word(w);
      send_word(w);
    end
    // all lanes out of credit
    check_flag("in_ready", in_ready, 1'b0);
    check_word("out_data", out_data, expq[0]);
    // one pop hands back one credit
    recv_word();
    check_flag("in_ready", in_ready, 1'b1);
    draw_word(w);
    send_word(w);
    check_flag("in_ready", in_ready, 1'b0);
  endtask

  task automatic test_drain_refill();
    stripe_pkg::word_t words [12];
    int total;
    int got;
    int n;
    for (int i = 0; i < 12; i++) begin
      draw_word(words[i]);
    end
    total = expq.size() + 12;
    fork
      begin
        for (int i = 0; i < 12; i++) begin
          send_word(words[i]);
        end
      end
      begin
        got = 0;
        n = 0;
        while (got < total) begin
          // random back-pressure
          take_bit(out_ready);
          if (out_ready && out_valid) begin
            if (expq.size() == 0) begin
              report_error("output word with nothing expected");
            end
            check_word("out_data", out_data, expq.pop_front());
            got++;
          end
          @(negedge clk);
          n++;
          if (n > wait_limit) begin
            report_error("drain did not finish in time");
          end
        end
        out_ready = 1'b0;
      end
    join
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("in_ready", in_ready, 1'b1);
    if (expq.size() != 0) begin
      report_error("expected words left after drain");
    end
  endtask

  // ----------------------------------------
  // sequence
  // ----------------------------------------

  initial begin
    clk        = 1'b0;
    nrst       = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b0;
    lfsr_state = 16'd22243;
    // four rising edges in reset
    repeat (4) @(negedge clk);
    nrst = 1'b1;
    @(negedge clk);

    test_reset_state();
    test_single_word();
    test_lane_order();
    test_capacity();
    test_drain_refill();

    // bound lane checkers only flag through their own counters
    if (lane_bad == '0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Verification failed");
      $fatal(1, "lane assertion failed during the run");
    end
  end

endmodule

// File: all.f
logic/stripe_pkg.sv
logic/lane_fifo.sv
logic/stripe_dispatch.sv
logic/stripe_collect.sv
logic/stripe_buffer.sv
dv/stripe_buffer_props.sv
dv/stripe_buffer_tb.sv

// File: Bender.yml
package:
  name: stripe_buffer

sources:
  # design
  - files:
      - logic/stripe_pkg.sv
      - logic/lane_fifo.sv
      - logic/stripe_dispatch.sv
      - logic/stripe_collect.sv
      - logic/stripe_buffer.sv
  # verification
  - target: test
    files:
      - dv/stripe_buffer_props.sv
      - dv/stripe_buffer_tb.sv
